/* bullet_unit.sv */
/*
 * Bullet unit for one tank.
 * Shoot edge detector, IDLE/FLYING/HIT state machine, bullet
 * position and the per-pixel bullet test against the scan.
 */
`default_nettype none

`include "tank_config.svh"

module bullet_unit (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            move_tick_i,
    input  logic            shoot_i,
    input  tank_pkg::pos_t  owner_pos_i,
    input  tank_pkg::dir_e  owner_heading_i,
    input  tank_pkg::scan_t scan_i,
    input  logic            hard_block_i,
    input  logic            other_bullet_i,
    input  logic            victim_hit_pulse_i,
    output logic            bullet_px_o,
    output logic            shoot_pulse_o
);
    import tank_pkg::*;

    localparam coord_t STEP = coord_t'(`TA_BULLET_STEP);
    localparam coord_t SIZE = coord_t'(`TA_BULLET_SIZE);
    localparam coord_t MID  = coord_t'(`TA_SPAWN_MID);
    localparam coord_t FAR  = coord_t'(`TA_SPAWN_FAR);
    localparam coord_t BACK = coord_t'(`TA_SPAWN_BACK);

    bullet_state_e state_q;
    dir_e          launch_dir_q;
    pos_t          bullet_q;
    pos_t          spawn;
    logic          shoot_d_q;
    logic          show_q;
    logic          collide;
    coord_t        dx, dy;

    ////////////////////////////////////////////////////////////
    // shoot edge and state machine
    ////////////////////////////////////////////////////////////

    assign collide = (bullet_px_o && hard_block_i)
                   || (bullet_px_o && other_bullet_i)
                   || victim_hit_pulse_i;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            shoot_d_q     <= 1'b0;
            shoot_pulse_o <= 1'b0;
            state_q       <= BULLET_IDLE;
            show_q        <= 1'b0;
        end else begin
            shoot_d_q     <= shoot_i;
            shoot_pulse_o <= shoot_i && !shoot_d_q;
            case (state_q)
                BULLET_IDLE: begin
                    show_q <= 1'b0;
                    if (shoot_pulse_o) begin
                        state_q <= BULLET_FLYING;
                    end
                end
                BULLET_FLYING: begin
                    show_q <= 1'b1;     // visible a cycle after launch
                    if (collide) begin
                        state_q <= BULLET_HIT;
                        show_q  <= 1'b0;
                    end
                end
                BULLET_HIT: begin
                    state_q <= BULLET_IDLE;
                end
                default: state_q <= BULLET_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // spawn point and flight
    ////////////////////////////////////////////////////////////

    always_comb begin
        spawn = bullet_q;
        case (owner_heading_i)
            DIR_DOWN: begin
                spawn.x = owner_pos_i.x + MID;
                spawn.y = owner_pos_i.y + FAR;
            end
            DIR_UP: begin
                spawn.x = owner_pos_i.x + MID;
                spawn.y = owner_pos_i.y - BACK;
            end
            DIR_RIGHT: begin
                spawn.x = owner_pos_i.x + FAR;
                spawn.y = owner_pos_i.y + MID;
            end
            DIR_LEFT: begin
                spawn.x = owner_pos_i.x - BACK;
                spawn.y = owner_pos_i.y + MID;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (state_q == BULLET_IDLE) begin
            launch_dir_q <= owner_heading_i;    // frozen once flying
        end
        if (move_tick_i) begin
            if (state_q == BULLET_IDLE) begin
                bullet_q <= spawn;
            end else if (state_q == BULLET_FLYING) begin
                case (launch_dir_q)
                    DIR_DOWN:  bullet_q.y <= bullet_q.y + STEP;
                    DIR_UP:    bullet_q.y <= bullet_q.y - STEP;
                    DIR_RIGHT: bullet_q.x <= bullet_q.x + STEP;
                    DIR_LEFT:  bullet_q.x <= bullet_q.x - STEP;
                    default: ;
                endcase
            end
        end
    end

    assign dx = scan_i.hpos - bullet_q.x;
    assign dy = scan_i.vpos - bullet_q.y;

    assign bullet_px_o = show_q && (dx <= SIZE) && (dy <= SIZE);

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
tank_pkg.sv
wall_sense.sv
tank_motion.sv
bullet_unit.sv
scene_judge.sv
tank_arena.sv
tank_arena_asserts.sv
tb_tank_arena.sv

/* scene_judge.sv */
/*
 * Scene judge.
 * Latches bullet hits on tanks, makes their rising-edge pulses,
 * mixes the player and bullet colours and flags block breaks.
 */
`default_nettype none

`include "tank_config.svh"

module scene_judge (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           p1_box_i,
    input  logic           p2_box_i,
    input  logic           p1_bullet_i,
    input  logic           p2_bullet_i,
    input  logic           destroyable_i,
    output logic           hit_p1_o,
    output logic           hit_p2_o,
    output logic           hit_p1_pulse_o,
    output logic           hit_p2_pulse_o,
    output logic           p1_visible_box_o,
    output logic           p2_visible_box_o,
    output tank_pkg::rgb_t player_rgb_o,
    output tank_pkg::rgb_t bullet_rgb_o,
    output logic           block_break_o
);
    import tank_pkg::*;

    logic hit_p1_d_q, hit_p2_d_q;
    logic any_bullet;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            hit_p1_o   <= 1'b0;
            hit_p2_o   <= 1'b0;
            hit_p1_d_q <= 1'b0;
            hit_p2_d_q <= 1'b0;
        end else begin
            if (p2_bullet_i && p1_box_i) begin
                hit_p1_o <= 1'b1;   // sticky until reset
            end
            if (p1_bullet_i && p2_box_i) begin
                hit_p2_o <= 1'b1;
            end
            hit_p1_d_q <= hit_p1_o;
            hit_p2_d_q <= hit_p2_o;
        end
    end

    assign hit_p1_pulse_o = hit_p1_o && !hit_p1_d_q;
    assign hit_p2_pulse_o = hit_p2_o && !hit_p2_d_q;

    assign p1_visible_box_o = p1_box_i && !hit_p1_o;  // a hit tank vanishes
    assign p2_visible_box_o = p2_box_i && !hit_p2_o;

    always_comb begin
        if (p1_visible_box_o) begin
            player_rgb_o = rgb_t'(`TA_P1_COLOR);
        end else if (p2_visible_box_o) begin
            player_rgb_o = rgb_t'(`TA_P2_COLOR);
        end else begin
            player_rgb_o = '0;
        end
    end

    assign any_bullet    = p1_bullet_i || p2_bullet_i;
    assign bullet_rgb_o  = any_bullet ? rgb_t'(`TA_BULLET_COLOR) : '0;
    assign block_break_o = destroyable_i && any_bullet;

endmodule

`default_nettype wire

/* tank_arena.sv */
/*
 * Tank arena player layer.
 * Two tanks with wall sensing and motion, one bullet each,
 * and the judge that resolves hits and output colours.
 */
`default_nettype none

`include "tank_config.svh"

module tank_arena (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            move_tick_i,
    input  tank_pkg::dir_e  p1_move_i,
    input  tank_pkg::dir_e  p2_move_i,
    input  logic            p1_shoot_i,
    input  logic            p2_shoot_i,
    input  tank_pkg::scan_t scan_i,
    input  tank_pkg::map_t  map_i,
    output tank_pkg::rgb_t  player_rgb_o,
    output tank_pkg::rgb_t  bullet_rgb_o,
    output logic            block_break_o,
    output logic            hit_p1_o,
    output logic            hit_p2_o
);
    import tank_pkg::*;

    localparam pos_t P1_START = '{x: coord_t'(`TA_P1_X0), y: coord_t'(`TA_P1_Y0)};
    localparam pos_t P2_START = '{x: coord_t'(`TA_P2_X0), y: coord_t'(`TA_P2_Y0)};

    pos_t   p1_pos, p2_pos;
    dir_e   p1_heading, p2_heading;
    sides_t p1_blocked, p2_blocked;
    logic   p1_box, p2_box;
    logic   p1_vis_box, p2_vis_box;
    logic   p1_shoot_pulse, p2_shoot_pulse;
    logic   p1_bullet, p2_bullet;
    logic   hit_p1_pulse, hit_p2_pulse;

    ////////////////////////////////////////////////////////////
    // tanks
    ////////////////////////////////////////////////////////////

    wall_sense u_p1_sense (
        .clk_i(clk_i), .reset_i(reset_i), .scan_i(scan_i), .pos_i(p1_pos),
        .move_i(p1_move_i), .shoot_pulse_i(p1_shoot_pulse),
        .cannot_walk_i(map_i.cannot_walk), .other_box_i(p2_vis_box),
        .box_o(p1_box), .blocked_o(p1_blocked)
    );

    wall_sense u_p2_sense (
        .clk_i(clk_i), .reset_i(reset_i), .scan_i(scan_i), .pos_i(p2_pos),
        .move_i(p2_move_i), .shoot_pulse_i(p2_shoot_pulse),
        .cannot_walk_i(map_i.cannot_walk), .other_box_i(p1_vis_box),
        .box_o(p2_box), .blocked_o(p2_blocked)
    );

    tank_motion #(.START_POS(P1_START), .START_HEADING(DIR_DOWN)) u_p1_motion (
        .clk_i(clk_i), .reset_i(reset_i), .move_tick_i(move_tick_i),
        .move_i(p1_move_i), .blocked_i(p1_blocked),
        .pos_o(p1_pos), .heading_o(p1_heading)
    );

    tank_motion #(.START_POS(P2_START), .START_HEADING(DIR_UP)) u_p2_motion (
        .clk_i(clk_i), .reset_i(reset_i), .move_tick_i(move_tick_i),
        .move_i(p2_move_i), .blocked_i(p2_blocked),
        .pos_o(p2_pos), .heading_o(p2_heading)
    );

    ////////////////////////////////////////////////////////////
    // bullets and judge
    ////////////////////////////////////////////////////////////

    bullet_unit u_p1_bullet (
        .clk_i(clk_i), .reset_i(reset_i), .move_tick_i(move_tick_i),
        .shoot_i(p1_shoot_i), .owner_pos_i(p1_pos), .owner_heading_i(p1_heading),
        .scan_i(scan_i), .hard_block_i(map_i.hard_block),
        .other_bullet_i(p2_bullet), .victim_hit_pulse_i(hit_p2_pulse),
        .bullet_px_o(p1_bullet), .shoot_pulse_o(p1_shoot_pulse)
    );

    bullet_unit u_p2_bullet (
        .clk_i(clk_i), .reset_i(reset_i), .move_tick_i(move_tick_i),
        .shoot_i(p2_shoot_i), .owner_pos_i(p2_pos), .owner_heading_i(p2_heading),
        .scan_i(scan_i), .hard_block_i(map_i.hard_block),
        .other_bullet_i(p1_bullet), .victim_hit_pulse_i(hit_p1_pulse),
        .bullet_px_o(p2_bullet), .shoot_pulse_o(p2_shoot_pulse)
    );

    scene_judge u_judge (
        .clk_i(clk_i), .reset_i(reset_i),
        .p1_box_i(p1_box), .p2_box_i(p2_box),
        .p1_bullet_i(p1_bullet), .p2_bullet_i(p2_bullet),
        .destroyable_i(map_i.destroyable),
        .hit_p1_o(hit_p1_o), .hit_p2_o(hit_p2_o),
        .hit_p1_pulse_o(hit_p1_pulse), .hit_p2_pulse_o(hit_p2_pulse),
        .p1_visible_box_o(p1_vis_box), .p2_visible_box_o(p2_vis_box),
        .player_rgb_o(player_rgb_o), .bullet_rgb_o(bullet_rgb_o),
        .block_break_o(block_break_o)
    );

endmodule

`default_nettype wire

/* tank_arena_asserts.sv */
/*
 * Tank arena assertions.
 * Hit flags are sticky, the two visible tank boxes never light
 * together and a block break only shows under a drawn bullet.
 */
`default_nettype none

`include "tank_config.svh"

module tank_arena_asserts (
    input logic           clk_i,
    input logic           reset_i,
    input logic           hit_p1_i,
    input logic           hit_p2_i,
    input logic           p1_vis_box_i,
    input logic           p2_vis_box_i,
    input logic           block_break_i,
    input tank_pkg::rgb_t bullet_rgb_i
);
    import tank_pkg::*;

    int fail_count = 0;     // read by the testbench

    sticky_hit_p1: assert property (@(posedge clk_i) disable iff (reset_i)
        hit_p1_i |=> hit_p1_i)
        else begin
            $error("tank 1 hit flag fell without reset");
            fail_count++;
        end

    sticky_hit_p2: assert property (@(posedge clk_i) disable iff (reset_i)
        hit_p2_i |=> hit_p2_i)
        else begin
            $error("tank 2 hit flag fell without reset");
            fail_count++;
        end

    one_player_colour: assert property (@(posedge clk_i) disable iff (reset_i)
        !(p1_vis_box_i && p2_vis_box_i))
        else begin
            $error("both tank boxes visible on the same pixel");
            fail_count++;
        end

    break_under_bullet: assert property (@(posedge clk_i) disable iff (reset_i)
        block_break_i |-> (bullet_rgb_i == rgb_t'(`TA_BULLET_COLOR)))
        else begin
            $error("block break without bullet colour");
            fail_count++;
        end

endmodule

bind tank_arena tank_arena_asserts u_asserts (
    .clk_i(clk_i), .reset_i(reset_i),
    .hit_p1_i(hit_p1_o), .hit_p2_i(hit_p2_o),
    .p1_vis_box_i(p1_vis_box), .p2_vis_box_i(p2_vis_box),
    .block_break_i(block_break_o), .bullet_rgb_i(bullet_rgb_o)
);

`default_nettype wire

/* tank_config.svh */
/*
 * Tank arena configuration.
 * Widths, start corners, speeds, box bounds, bullet spawn
 * offsets and the solid colours used for tanks and bullets.
 */
`ifndef TANK_CONFIG_SVH
`define TANK_CONFIG_SVH

`define TA_COORD_W        10    // screen coordinate bits
`define TA_COLOR_W        8     // bits per colour channel

// start corners, upper left of each tank
`define TA_P1_X0          224
`define TA_P1_Y0          32
`define TA_P2_X0          224
`define TA_P2_Y0          416

`define TA_MOVE_STEP      1     // tank pixels per tick
`define TA_BULLET_STEP    4     // bullet pixels per tick

`define TA_BOX_LO         3     // inner box, offset from corner
`define TA_BOX_HI         28
`define TA_BULLET_SIZE    4

// bullet spawn point relative to the tank corner
`define TA_SPAWN_MID      14
`define TA_SPAWN_FAR      32
`define TA_SPAWN_BACK     4

// colour words packed as {blue, green, red}
`define TA_P1_COLOR       24'h30C040
`define TA_P2_COLOR       24'hD04020
`define TA_BULLET_COLOR   24'hFFFFFF

`endif

/* tank_motion.sv */
/*
 * Tank motion.
 * Holds one tank's corner position and heading, stepping one
 * move step per tick unless the commanded side is blocked.
 */
`default_nettype none

`include "tank_config.svh"

module tank_motion #(
    parameter tank_pkg::pos_t START_POS     = '0,
    parameter tank_pkg::dir_e START_HEADING = tank_pkg::DIR_DOWN
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             move_tick_i,
    input  tank_pkg::dir_e   move_i,
    input  tank_pkg::sides_t blocked_i,
    output tank_pkg::pos_t   pos_o,
    output tank_pkg::dir_e   heading_o
);
    import tank_pkg::*;

    localparam coord_t STEP = coord_t'(`TA_MOVE_STEP);

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            pos_o     <= START_POS;
            heading_o <= START_HEADING;
        end else if (move_tick_i) begin
            case (move_i)
                DIR_DOWN: begin
                    if (!blocked_i.bottom) begin
                        pos_o.y   <= pos_o.y + STEP;
                        heading_o <= DIR_DOWN;
                    end
                end
                DIR_UP: begin
                    if (!blocked_i.top) begin
                        pos_o.y   <= pos_o.y - STEP;
                        heading_o <= DIR_UP;
                    end
                end
                DIR_RIGHT: begin
                    if (!blocked_i.right) begin
                        pos_o.x   <= pos_o.x + STEP;
                        heading_o <= DIR_RIGHT;
                    end
                end
                DIR_LEFT: begin
                    if (!blocked_i.left) begin
                        pos_o.x   <= pos_o.x - STEP;
                        heading_o <= DIR_LEFT;
                    end
                end
                default: ;  // no command, hold
            endcase
        end
    end

endmodule

`default_nettype wire

/* tank_pkg.sv */
/*
 * Tank arena types.
 * Heading and bullet state encodings, plus the packed structs
 * for positions, blocked sides, scan position, colour and map class.
 */
`default_nettype none

`include "tank_config.svh"

package tank_pkg;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    // one-hot move command and heading
    typedef enum logic [3:0] {
        DIR_NONE  = 4'b0000,
        DIR_DOWN  = 4'b0001,
        DIR_UP    = 4'b0010,
        DIR_RIGHT = 4'b0100,
        DIR_LEFT  = 4'b1000
    } dir_e;

    typedef enum logic [1:0] {
        BULLET_IDLE   = 2'b00,  // parked at spawn point
        BULLET_FLYING = 2'b01,
        BULLET_HIT    = 2'b10   // one cycle before rearm
    } bullet_state_e;

    ////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////

    typedef logic [`TA_COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } sides_t;

    typedef struct packed {
        coord_t hpos;
        coord_t vpos;
    } scan_t;

    typedef struct packed {
        logic [`TA_COLOR_W-1:0] blue;
        logic [`TA_COLOR_W-1:0] green;
        logic [`TA_COLOR_W-1:0] red;
    } rgb_t;

    typedef struct packed {
        logic cannot_walk;
        logic hard_block;
        logic destroyable;
    } map_t;

endpackage

`default_nettype wire

/* tb_tank_arena.sv */
/*
 * Testbench for the tank arena player layer.
 * Directed tests for start colours, movement, side blocking,
 * bullet flight, tank hits and block breaks.
 */
`default_nettype none

`include "tank_config.svh"

module tb_tank_arena;
    import tank_pkg::*;

    localparam int PERIOD       = 8;
    localparam int MOVE_TICKS   = 5;
    localparam int FLIGHT_TICKS = 120;
    localparam int RUN_CYCLES   = 8 + 20 + 10 * 6 + 40 + 60 + FLIGHT_TICKS * 6 + 40;
    localparam int LO = `TA_BOX_LO;
    localparam int HI = `TA_BOX_HI;
    localparam logic [23:0] P1_C = `TA_P1_COLOR;
    localparam logic [23:0] P2_C = `TA_P2_COLOR;
    localparam logic [23:0] BUL_C = `TA_BULLET_COLOR;
    localparam map_t MAP_FREE  = map_t'(3'b000);
    localparam map_t MAP_WALL  = map_t'(3'b100);    // cannot_walk
    localparam map_t MAP_HARD  = map_t'(3'b010);
    localparam map_t MAP_BREAK = map_t'(3'b001);    // destroyable

    logic  clk, reset, move_tick, p1_shoot, p2_shoot;
    dir_e  p1_move, p2_move;
    scan_t scan;
    map_t  map;
    rgb_t  player_rgb, bullet_rgb;
    logic  block_break, hit_p1, hit_p2;

    string test_name;
    int    test_errors, total_errors, tests_run, tests_failed;
    int    p1_x, p1_y, bx, by;

    tank_arena dut0 (
        .clk_i(clk), .reset_i(reset), .move_tick_i(move_tick),
        .p1_move_i(p1_move), .p2_move_i(p2_move),
        .p1_shoot_i(p1_shoot), .p2_shoot_i(p2_shoot),
        .scan_i(scan), .map_i(map),
        .player_rgb_o(player_rgb), .bullet_rgb_o(bullet_rgb),
        .block_break_o(block_break), .hit_p1_o(hit_p1), .hit_p2_o(hit_p2)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * 2 * PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [23:0] expected,
                               input logic [23:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic look_at(input int x, input int y, input map_t cls);
        next_cycle();
        scan.hpos = coord_t'(x);
        scan.vpos = coord_t'(y);
        map       = cls;
        #2;     // outputs settle well before the next edge
    endtask

    task automatic tick_move();
        int gap;
        gap = $urandom_range(3, 0);
        next_cycle();
        repeat (gap) next_cycle();
        move_tick = 1'b1;
        next_cycle();
        move_tick = 1'b0;
    endtask

    task automatic fire_and_wait(input bit player2, input int x, input int y);
        int waited;
        waited = 0;
        next_cycle();
        if (player2) begin
            p2_shoot = 1'b1;
        end else begin
            p1_shoot = 1'b1;
        end
        scan.hpos = coord_t'(x);
        scan.vpos = coord_t'(y);
        map       = MAP_FREE;
        #1;
        while (bullet_rgb !== BUL_C && waited < 10) begin
            next_cycle();
            #1;
            waited++;
        end
        p1_shoot = 1'b0;
        p2_shoot = 1'b0;
        assert (bullet_rgb === BUL_C) else begin
            $display("test %s: bullet never appeared at its spawn point", test_name);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s finished cleanly", test_name);
        end else begin
            tests_failed++;
            total_errors += test_errors;
            $display("test %s finished with %0d errors", test_name, test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_colours();
        start_test("reset_colours");
        look_at(`TA_P1_X0 + LO, `TA_P1_Y0 + LO, MAP_FREE);
        check_value("tank 1 box", P1_C, player_rgb);
        look_at(`TA_P2_X0 + LO, `TA_P2_Y0 + LO, MAP_FREE);
        check_value("tank 2 box", P2_C, player_rgb);
        look_at(100, 200, MAP_FREE);
        check_value("empty pixel", 24'h0, player_rgb);
        finish_test();
    endtask

    task automatic test_movement();
        start_test("movement");
        next_cycle();
        p1_move = DIR_RIGHT;
        repeat (MOVE_TICKS) tick_move();
        p1_move = DIR_NONE;
        p1_x += MOVE_TICKS * `TA_MOVE_STEP;
        look_at(p1_x + HI, p1_y + 10, MAP_FREE);
        check_value("right edge inside", P1_C, player_rgb);
        look_at(p1_x + HI + 1, p1_y + 10, MAP_FREE);
        check_value("right edge outside", 24'h0, player_rgb);
        finish_test();
    endtask

    task automatic test_blocking();
        start_test("blocking");
        next_cycle();
        p1_move = DIR_RIGHT;
        look_at(p1_x + HI + 1, p1_y + 10, MAP_WALL);    // wall on right band
        look_at(100, 200, MAP_FREE);
        repeat (3) tick_move();
        look_at(p1_x + HI, p1_y + 10, MAP_FREE);
        check_value("blocked edge inside", P1_C, player_rgb);
        look_at(p1_x + HI + 1, p1_y + 10, MAP_FREE);
        check_value("blocked edge outside", 24'h0, player_rgb);
        next_cycle();
        p1_move = DIR_LEFT;
        tick_move();
        p1_move = DIR_NONE;
        p1_x -= `TA_MOVE_STEP;
        look_at(p1_x + HI, p1_y + 10, MAP_FREE);
        check_value("left step inside", P1_C, player_rgb);
        look_at(p1_x + HI + 1, p1_y + 10, MAP_FREE);
        check_value("left step outside", 24'h0, player_rgb);
        finish_test();
    endtask

    task automatic test_bullet_flight();
        int sx, sy;
        start_test("bullet_flight");
        sx = `TA_P2_X0 + `TA_SPAWN_MID;     // tank 2 heads up
        sy = `TA_P2_Y0 - `TA_SPAWN_BACK;
        tick_move();
        fire_and_wait(1'b1, sx + 1, sy + 1);
        repeat (2) begin
            tick_move();
            sy -= `TA_BULLET_STEP;
            look_at(sx + 1, sy + 1, MAP_FREE);
            check_value("bullet front", BUL_C, bullet_rgb);
            look_at(sx + 1, sy + `TA_BULLET_SIZE + 1, MAP_FREE);
            check_value("bullet trail", 24'h0, bullet_rgb);
        end
        look_at(sx + 2, sy + 2, MAP_HARD);
        look_at(sx + 2, sy + 2, MAP_FREE);
        check_value("after hard block", 24'h0, bullet_rgb);
        tick_move();
        sy = `TA_P2_Y0 - `TA_SPAWN_BACK;
        fire_and_wait(1'b1, sx + 1, sy + 1);
        look_at(sx + 2, sy + 2, MAP_HARD);
        look_at(sx + 2, sy + 2, MAP_FREE);
        check_value("second shot stopped", 24'h0, bullet_rgb);
        finish_test();
    endtask

    task automatic test_tank_hit();
        int target_y, ticks, expected_ticks;
        start_test("tank_hit");
        next_cycle();
        p1_move = DIR_DOWN;
        tick_move();
        p1_move = DIR_NONE;
        p1_y += `TA_MOVE_STEP;
        tick_move();    // reload spawn with the new heading
        bx = p1_x + `TA_SPAWN_MID;
        by = p1_y + `TA_SPAWN_FAR;
        fire_and_wait(1'b0, bx + 1, by + 1);
        target_y = `TA_P2_Y0 + LO;
        expected_ticks = (target_y - `TA_BULLET_SIZE - by + `TA_BULLET_STEP - 1)
                       / `TA_BULLET_STEP;
        look_at(bx + 1, target_y, MAP_FREE);
        ticks = 0;
        while (!hit_p2 && ticks < FLIGHT_TICKS) begin
            tick_move();
            next_cycle();
            ticks++;
        end
        check_value("hit flag", 24'h1, hit_p2);
        check_value("ticks to hit", expected_ticks, ticks);
        repeat (5) next_cycle();
        check_value("hit flag held", 24'h1, hit_p2);
        check_value("tank 1 not hit", 24'h0, hit_p1);
        look_at(`TA_P2_X0 + LO + 5, `TA_P2_Y0 + LO + 5, MAP_FREE);
        check_value("hit tank hidden", 24'h0, player_rgb);
        look_at(bx + 1, target_y, MAP_FREE);
        check_value("bullet removed", 24'h0, bullet_rgb);
        finish_test();
    endtask

    task automatic test_block_break();
        start_test("block_break");
        tick_move();
        fire_and_wait(1'b0, bx + 1, by + 1);
        look_at(bx + 2, by + 2, MAP_BREAK);
        check_value("break on bullet", 24'h1, block_break);
        look_at(bx + 2, by + 2, MAP_FREE);
        check_value("bullet on plain pixel", 24'h0, block_break);
        look_at(bx + `TA_BULLET_SIZE + 2, by + 2, MAP_BREAK);
        check_value("breakable without bullet", 24'h0, block_break);
        finish_test();
    endtask

    initial begin
        void'($urandom(32'ha1a4_4b40));
        reset        = 1'b1;
        move_tick    = 1'b0;
        p1_move      = DIR_NONE;
        p2_move      = DIR_NONE;
        p1_shoot     = 1'b0;
        p2_shoot     = 1'b0;
        scan         = '0;
        map          = MAP_FREE;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        p1_x         = `TA_P1_X0;
        p1_y         = `TA_P1_Y0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_colours();
        test_movement();
        test_blocking();
        test_bullet_flight();
        test_tank_hit();
        test_block_break();
        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, total_errors, dut0.u_asserts.fail_count);
        if (total_errors == 0 && dut0.u_asserts.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* wall_sense.sv */
/*
 * Wall sense for one tank.
 * Tests the scan against the tank's inner box and the one-pixel
 * bands just outside each side, and keeps a blocked flag per side.
 */
`default_nettype none

`include "tank_config.svh"

module wall_sense (
    input  logic             clk_i,
    input  logic             reset_i,
    input  tank_pkg::scan_t  scan_i,
    input  tank_pkg::pos_t   pos_i,
    input  tank_pkg::dir_e   move_i,
    input  logic             shoot_pulse_i,
    input  logic             cannot_walk_i,
    input  logic             other_box_i,
    output logic             box_o,
    output tank_pkg::sides_t blocked_o
);
    import tank_pkg::*;

    localparam coord_t LO = coord_t'(`TA_BOX_LO);
    localparam coord_t HI = coord_t'(`TA_BOX_HI);

    coord_t rel_x, rel_y;
    logic   span_x, span_y;
    sides_t band;
    sides_t keep;
    logic   wall_hit;

    assign rel_x = scan_i.hpos - pos_i.x;   // wraps when left of corner
    assign rel_y = scan_i.vpos - pos_i.y;

    assign box_o = (rel_x >= LO) && (rel_x <= HI) && (rel_y >= LO) && (rel_y <= HI);

    // bands stop one pixel short of the corners
    assign span_x = (rel_x >= LO + 1) && (rel_x <= HI - 1);
    assign span_y = (rel_y >= LO + 1) && (rel_y <= HI - 1);

    assign band.top    = (rel_y == LO - 1) && span_x;
    assign band.bottom = (rel_y == HI + 1) && span_x;
    assign band.left   = (rel_x == LO - 1) && span_y;
    assign band.right  = (rel_x == HI + 1) && span_y;

    assign wall_hit = cannot_walk_i || other_box_i;

    ////////////////////////////////////////////////////////////
    // blocked flags
    ////////////////////////////////////////////////////////////

    always_comb begin
        keep.top    = !(move_i inside {DIR_DOWN, DIR_RIGHT, DIR_LEFT});
        keep.bottom = !(move_i inside {DIR_UP, DIR_RIGHT, DIR_LEFT});
        keep.left   = !(move_i inside {DIR_DOWN, DIR_UP, DIR_RIGHT});
        keep.right  = !(move_i inside {DIR_DOWN, DIR_UP, DIR_LEFT});
        if (shoot_pulse_i) begin
            keep = '0;  // firing frees every side
        end
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            blocked_o <= '0;
        end else begin
            // setting wins over clearing on the same cycle
            blocked_o <= (blocked_o & keep) | (band & {4{wall_hit}});
        end
    end

endmodule

`default_nettype wire
